/* src.f */
+incdir+source
source/cmd_pkg.sv
source/cmd_queue.sv
source/sc_param_decoder.sv
source/dac_param_decoder.sv
source/run_mode_decoder.sv
source/usb_cmd_interpreter.sv
dv/cmd_interp_chk.sv
dv/tb_cmd_interp.sv

/* Makefile */
TOP = tb_cmd_interp

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/tb_cmd_interp.sv */
`timescale 1ns/1ns
`include "cmd_defs.svh"

module tb_cmd_interp;

  localparam int BURSTS      = 12;
  localparam int BURST_LEN   = 24;
  localparam int IDLE_CYCLES = `QUEUE_DEPTH + 4;
  localparam int CYCLE_LIMIT = BURSTS * (BURST_LEN + IDLE_CYCLES) * 2;
  localparam logic [15:0] CPT_TABLE [8] = '{16'd200, 16'd1000, 16'd2000, 16'd5000,
                                             16'd10000, 16'd20000, 16'd40000, 16'd50000};

  logic              clk;
  logic              reset_n;
  logic              cmd_valid;
  cmd_pkg::cmd_t     cmd_word;
  logic              cmd_ready;
  cmd_pkg::sc_cfg_t  sc_cfg;
  cmd_pkg::dac_cfg_t dac_cfg;
  cmd_pkg::run_cfg_t run_cfg;
  logic              param_load;
  logic              counter_reset;
  logic              data_clear;

  logic [31:0]       lfsr;
  int                cycles;
  int                load_seen;
  int                cnt_rst_seen;
  int                clear_seen;
  int                load_exp;
  int                cnt_rst_exp;
  int                clear_exp;
  cmd_pkg::sc_cfg_t  exp_sc;
  cmd_pkg::dac_cfg_t exp_dac;
  cmd_pkg::run_cfg_t exp_run;
  cmd_pkg::cmd_t     last_word;

  usb_cmd_interpreter i_usb_cmd_interpreter (
    .clk           (clk),
    .reset_n       (reset_n),
    .cmd_valid     (cmd_valid),
    .cmd_word      (cmd_word),
    .cmd_ready     (cmd_ready),
    .sc_cfg        (sc_cfg),
    .dac_cfg       (dac_cfg),
    .run_cfg       (run_cfg),
    .param_load    (param_load),
    .counter_reset (counter_reset),
    .data_clear    (data_clear)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Pulse counting and run limit
  always @(negedge clk) begin
    cycles++;
    load_seen    += int'(param_load);
    cnt_rst_seen += int'(counter_reset);
    clear_seen   += int'(data_clear);
    if (cycles > CYCLE_LIMIT) begin
      $display("Run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // Random words
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic cmd_pkg::cmd_t get_bits(input int n);
    cmd_pkg::cmd_t value;
    logic          fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr  = {lfsr[30:0], fb};
      value = {value[14:0], fb};
    end
    return value;
  endfunction

  // Mask codes are all-ones, zero, or 0..127 across the channel range
  function automatic cmd_pkg::cmd_t mask_code();
    cmd_pkg::cmd_t sel;
    sel = get_bits(2);
    if (sel == 16'd0) return 16'h00FF;
    if (sel == 16'd1) return 16'h0000;
    return get_bits(7);
  endfunction

  function automatic cmd_pkg::cmd_t make_word();
    cmd_pkg::cmd_t kind;
    cmd_pkg::cmd_t w;
    kind = get_bits(5);
    case (kind)
      0:          w = `SC_SEL_SC | get_bits(1);
      1:          w = {`ASIC_NUM_PFX, 4'h0} | get_bits(4);
      2, 3:       w = {`CTEST_PFX, 8'h00} | mask_code();
      4:          w = {`READ_REG_PFX, 8'h00} | mask_code();
      5:          w = {`TRIG_COINCID_PFX, 4'h0} | get_bits(4);
      6:          w = {`HOLD_DELAY_PFX, 8'h00} | get_bits(8);
      7:          w = {`HEADER_PFX, 8'h00} | get_bits(8);
      8:          w = `CNT_RESET;
      9:          w = `PARAM_LOAD;
      10:         w = {`VTH0_PFX, 10'h0} | get_bits(10);
      11:         w = {`VTH1_PFX, 10'h0} | get_bits(10);
      12:         w = {`VTH2_PFX, 10'h0} | get_bits(10);
      13, 14, 15: w = {`TRIM_PFX, 10'h0} | get_bits(10);
      16:         w = `ACQ_START;
      17:         w = `ACQ_STOP;
      18:         w = `DATA_CLEAR;
      19:         w = `ACQ_MODE_SET | get_bits(1);
      20:         w = `SINGLE_SET | get_bits(1);
      21:         w = `CTEST_IN_SET | get_bits(1);
      22:         w = `SCTEST_START | get_bits(1);
      23:         w = {`TEST_CHN_PFX, 8'h00} | get_bits(8);
      24, 25:     w = {`CPT_MAX_PFX, 8'h00} | get_bits(4);
      26:         w = {`CPT_MAX_PFX, 8'h00} | get_bits(8);
      default:    w = get_bits(16);
    endcase
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [9:0] reverse_bits(input logic [9:0] v, input int width);
    logic [9:0] r;
    r = '0;
    for (int i = 0; i < width; i++) r[width-1-i] = v[i];
    return r;
  endfunction

  function automatic logic [63:0] build_mask(input logic [7:0] n, input logic allow_all);
    logic [63:0] m;
    for (int i = 0; i < 64; i++) m[i] = (int'(n) == i + 1);
    if (allow_all && n == 8'hFF) m = '1;
    return m;
  endfunction

  task automatic init_model();
    exp_sc          = '0;
    exp_sc.asic_num = `ASIC_NUM_RST;
    exp_sc.header   = `HEADER_RST;
    exp_dac         = '0;
    exp_dac.vth0    = `VTH_RST;
    exp_dac.vth1    = `VTH_RST;
    exp_dac.vth2    = `VTH_RST;
    exp_run         = '0;
    exp_run.acq_mode    = 1'b1;
    exp_run.single_chn  = 1'b1;
    exp_run.ctest_input = 1'b1;
    exp_run.cpt_max     = `CPT_MAX_RST;
  endtask

  task automatic update_model(input cmd_pkg::cmd_t w);
    logic [9:0] rev;
    logic [9:0] hdr_rev;
    int         chn;
    rev     = reverse_bits(w[9:0], 10);
    hdr_rev = reverse_bits({2'b00, w[7:0]}, 8);
    if (w == `SC_SEL_SC || w == `SC_SEL_READ) exp_sc.sc_or_read = w[0];
    if (w[15:4] == `ASIC_NUM_PFX) exp_sc.asic_num = w[2:0];
    if (w[15:8] == `CTEST_PFX) exp_sc.ctest_mask = build_mask(w[7:0], 1'b1);
    if (w[15:8] == `READ_REG_PFX) exp_sc.read_mask = build_mask(w[7:0], 1'b0);
    if (w[15:4] == `TRIG_COINCID_PFX) exp_sc.trig_coincid = w[1:0];
    if (w[15:8] == `HOLD_DELAY_PFX) exp_sc.hold_delay = w[4:0];
    if (w[15:8] == `HEADER_PFX) exp_sc.header = hdr_rev[7:0];
    if (w[15:10] == `VTH0_PFX) exp_dac.vth0 = rev;
    if (w[15:10] == `VTH1_PFX) exp_dac.vth1 = rev;
    if (w[15:10] == `VTH2_PFX) exp_dac.vth2 = rev;
    if (w[15:10] == `TRIM_PFX) begin
      chn = int'(w[11:4]) - 192;
      exp_dac.trim[chn] = w[3:0];
    end
    if (w[15:8] == `TEST_CHN_PFX) exp_run.test_chn = w[5:0];
    if (w[15:8] == `CPT_MAX_PFX) begin
      exp_run.cpt_max = (w[7:0] < 8'd8) ? CPT_TABLE[w[2:0]] : `CPT_MAX_RST;
    end
    case (w)
      `ACQ_START, `ACQ_STOP:         exp_run.acq_run     = (w == `ACQ_START);
      `ACQ_MODE_SET, `ACQ_MODE_CLR:  exp_run.acq_mode    = (w == `ACQ_MODE_SET);
      `SINGLE_SET, `SINGLE_CLR:      exp_run.single_chn  = (w == `SINGLE_SET);
      `CTEST_IN_SET, `CTEST_IN_CLR:  exp_run.ctest_input = (w == `CTEST_IN_SET);
      `SCTEST_START, `SCTEST_STOP:   exp_run.sctest_run  = (w == `SCTEST_START);
      `PARAM_LOAD:                   load_exp++;
      `CNT_RESET:                    cnt_rst_exp++;
      `DATA_CLEAR:                   clear_exp++;
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [319:0] expected,
                             input logic [319:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_outputs(input string tag);
    check_value($sformatf("%s cmd_ready", tag), 1'b1, cmd_ready);
    check_value($sformatf("%s sc_cfg", tag), exp_sc, sc_cfg);
    check_value($sformatf("%s dac_cfg", tag), exp_dac, dac_cfg);
    check_value($sformatf("%s run_cfg", tag), exp_run, run_cfg);
    check_value($sformatf("%s param_load count", tag), load_exp, load_seen);
    check_value($sformatf("%s counter_reset count", tag), cnt_rst_exp, cnt_rst_seen);
    check_value($sformatf("%s data_clear count", tag), clear_exp, clear_seen);
  endtask

  // The queue drains every cycle so an offered word is never refused
  task automatic send_word(input cmd_pkg::cmd_t w);
    cmd_valid = 1'b1;
    cmd_word  = w;
    check_value($sformatf("cmd_ready for word %h", w), 1'b1, cmd_ready);
    @(posedge clk);
    #5;
    update_model(w);
  endtask

  task automatic run_burst(input logic gaps);
    cmd_pkg::cmd_t w;
    for (int i = 0; i < BURST_LEN; i++) begin
      w = make_word();
      // Same pulse word twice in a row would merge into one long pulse
      if (w == last_word && (w == `PARAM_LOAD || w == `CNT_RESET || w == `DATA_CLEAR))
        w = `ACQ_STOP;
      send_word(w);
      last_word = w;
      if (gaps && get_bits(2) == 16'd0) begin
        cmd_valid = 1'b0;
        @(posedge clk);
        #5;
      end
    end
    cmd_valid = 1'b0;
  endtask

  initial begin
    lfsr      = 32'h12fc_3492;
    reset_n   = 1'b1;
    cmd_valid = 1'b0;
    cmd_word  = '0;
    last_word = '0;
    init_model();
    #1 reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #5 reset_n = 1'b1;
    compare_outputs("reset");
    // Last burst runs with no gaps
    for (int b = 0; b < BURSTS; b++) begin
      run_burst(b != BURSTS - 1);
      repeat (IDLE_CYCLES) @(posedge clk);
      #5;
      compare_outputs($sformatf("burst %0d", b));
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* dv/cmd_interp_chk.sv */
`timescale 1ns/1ns

module cmd_interp_chk (
  input logic              clk,
  input logic              reset_n,
  input logic              cmd_ready,
  input logic              param_load,
  input logic              counter_reset,
  input logic              data_clear,
  input cmd_pkg::sc_cfg_t  sc_cfg,
  input cmd_pkg::dac_cfg_t dac_cfg,
  input cmd_pkg::run_cfg_t run_cfg
);

  localparam int OUT_W = $bits(cmd_pkg::sc_cfg_t) + $bits(cmd_pkg::dac_cfg_t)
                       + $bits(cmd_pkg::run_cfg_t) + 4;

  logic [OUT_W-1:0] outs;
  logic             in_reset_prev;

  // All outputs in one vector
  assign outs = {sc_cfg, dac_cfg, run_cfg, cmd_ready, param_load, counter_reset, data_clear};

  // Reset seen at the previous edge
  always_ff @(posedge clk) begin
    in_reset_prev <= !reset_n;
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  param_load_single: assert property (@(posedge clk) disable iff (!reset_n)
    param_load |=> !param_load) else $error("param_load high two cycles running");

  counter_reset_single: assert property (@(posedge clk) disable iff (!reset_n)
    counter_reset |=> !counter_reset) else $error("counter_reset high two cycles running");

  data_clear_single: assert property (@(posedge clk) disable iff (!reset_n)
    data_clear |=> !data_clear) else $error("data_clear high two cycles running");

  ready_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> cmd_ready) else $error("cmd_ready low right after reset");

  hold_in_reset: assert property (@(posedge clk)
    (!reset_n && in_reset_prev) |-> $stable(outs)) else $error("output moved during reset");

endmodule

bind usb_cmd_interpreter cmd_interp_chk i_cmd_interp_chk (
  .clk           (clk),
  .reset_n       (reset_n),
  .cmd_ready     (cmd_ready),
  .param_load    (param_load),
  .counter_reset (counter_reset),
  .data_clear    (data_clear),
  .sc_cfg        (sc_cfg),
  .dac_cfg       (dac_cfg),
  .run_cfg       (run_cfg)
);

/* source/usb_cmd_interpreter.sv */
`timescale 1ns/1ns

module usb_cmd_interpreter (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              cmd_valid,
  input  cmd_pkg::cmd_t     cmd_word,
  output logic              cmd_ready,
  output cmd_pkg::sc_cfg_t  sc_cfg,
  output cmd_pkg::dac_cfg_t dac_cfg,
  output cmd_pkg::run_cfg_t run_cfg,
  output logic              param_load,
  output logic              counter_reset,
  output logic              data_clear
);

  // Shared by all three decoders
  cmd_pkg::cmd_beat_t beat;

  cmd_queue i_cmd_queue (
    .clk      (clk),
    .reset_n  (reset_n),
    .in_valid (cmd_valid),
    .in_word  (cmd_word),
    .in_ready (cmd_ready),
    .beat     (beat)
  );

  ////////////////////////////////////////////////////////////
  // Decoders, one per command class
  ////////////////////////////////////////////////////////////

  sc_param_decoder i_sc_param_decoder (
    .clk           (clk),
    .reset_n       (reset_n),
    .beat          (beat),
    .sc_cfg        (sc_cfg),
    .param_load    (param_load),
    .counter_reset (counter_reset)
  );

  dac_param_decoder i_dac_param_decoder (
    .clk     (clk),
    .reset_n (reset_n),
    .beat    (beat),
    .dac_cfg (dac_cfg)
  );

  run_mode_decoder i_run_mode_decoder (
    .clk        (clk),
    .reset_n    (reset_n),
    .beat       (beat),
    .run_cfg    (run_cfg),
    .data_clear (data_clear)
  );

endmodule

/* source/run_mode_decoder.sv */
`timescale 1ns/1ns
`include "cmd_defs.svh"

module run_mode_decoder (
  input  logic               clk,
  input  logic               reset_n,
  input  cmd_pkg::cmd_beat_t beat,
  output cmd_pkg::run_cfg_t  run_cfg,
  output logic               data_clear
);

  // Maximum count table for the S-curve counter
  function automatic logic [15:0] cpt_lookup(input logic [7:0] code);
    logic [15:0] value;
    case (code)
      8'h00:   value = 16'd200;
      8'h01:   value = 16'd1000;
      8'h02:   value = 16'd2000;
      8'h03:   value = 16'd5000;
      8'h04:   value = 16'd10000;
      8'h05:   value = 16'd20000;
      8'h06:   value = 16'd40000;
      8'h07:   value = 16'd50000;
      default: value = `CPT_MAX_RST;
    endcase
    return value;
  endfunction

  logic hit_test_chn;
  logic hit_cpt_max;

  assign hit_test_chn = beat.valid && (beat.word[15:8] == `TEST_CHN_PFX);
  assign hit_cpt_max  = beat.valid && (beat.word[15:8] == `CPT_MAX_PFX);

  ////////////////////////////////////////////////////////////
  // Run and test mode registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      run_cfg.acq_run     <= 1'b0;
      run_cfg.acq_mode    <= 1'b1;
      run_cfg.single_chn  <= 1'b1;
      run_cfg.ctest_input <= 1'b1;
      run_cfg.test_chn    <= '0;
      run_cfg.cpt_max     <= `CPT_MAX_RST;
      run_cfg.sctest_run  <= 1'b0;
    end else begin
      if (beat.valid) begin
        case (beat.word)
          `ACQ_START:    run_cfg.acq_run     <= 1'b1;
          `ACQ_STOP:     run_cfg.acq_run     <= 1'b0;
          // acq_mode 1 is acquisition, 0 is S-curve
          `ACQ_MODE_SET: run_cfg.acq_mode    <= 1'b1;
          `ACQ_MODE_CLR: run_cfg.acq_mode    <= 1'b0;
          `SINGLE_SET:   run_cfg.single_chn  <= 1'b1;
          `SINGLE_CLR:   run_cfg.single_chn  <= 1'b0;
          `CTEST_IN_SET: run_cfg.ctest_input <= 1'b1;
          `CTEST_IN_CLR: run_cfg.ctest_input <= 1'b0;
          `SCTEST_START: run_cfg.sctest_run  <= 1'b1;
          `SCTEST_STOP:  run_cfg.sctest_run  <= 1'b0;
          default:       ;
        endcase
      end
      // Only matters in single-channel mode
      if (hit_test_chn) begin
        run_cfg.test_chn <= beat.word[$clog2(`CHN_NUM)-1:0];
      end
      if (hit_cpt_max) begin
        run_cfg.cpt_max <= cpt_lookup(beat.word[7:0]);
      end
    end
  end

  // Data queue clear pulse
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      data_clear <= 1'b0;
    end else begin
      data_clear <= beat.valid && (beat.word == `DATA_CLEAR);
    end
  end

endmodule

/* source/dac_param_decoder.sv */
`timescale 1ns/1ns
`include "cmd_defs.svh"

module dac_param_decoder (
  input  logic               clk,
  input  logic               reset_n,
  input  cmd_pkg::cmd_beat_t beat,
  output cmd_pkg::dac_cfg_t  dac_cfg
);

  logic                        hit_vth0;
  logic                        hit_vth1;
  logic                        hit_vth2;
  logic                        hit_trim;
  logic [$clog2(`CHN_NUM)-1:0] trim_chn;

  // Threshold prefixes take the top six bits, leaving a 10-bit value
  assign hit_vth0 = beat.valid && (beat.word[15:10] == `VTH0_PFX);
  assign hit_vth1 = beat.valid && (beat.word[15:10] == `VTH1_PFX);
  assign hit_vth2 = beat.valid && (beat.word[15:10] == `VTH2_PFX);
  assign hit_trim = beat.valid && (beat.word[15:10] == `TRIM_PFX);

  // CC0x..CFFx maps onto channels 0..63
  assign trim_chn = 6'(beat.word[11:4] - `TRIM_CHN_BASE);

  ////////////////////////////////////////////////////////////
  // Threshold and trim registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dac_cfg.vth0 <= `VTH_RST;
      dac_cfg.vth1 <= `VTH_RST;
      dac_cfg.vth2 <= `VTH_RST;
      dac_cfg.trim <= '0;
    end else begin
      // DAC codes are stored MSB-last for the shift chain
      if (hit_vth0) begin
        dac_cfg.vth0 <= {<<{beat.word[`VTH_W-1:0]}};
      end
      if (hit_vth1) begin
        dac_cfg.vth1 <= {<<{beat.word[`VTH_W-1:0]}};
      end
      if (hit_vth2) begin
        dac_cfg.vth2 <= {<<{beat.word[`VTH_W-1:0]}};
      end
      if (hit_trim) begin
        dac_cfg.trim[trim_chn] <= beat.word[`TRIM_W-1:0];
      end
    end
  end

endmodule

/* source/sc_param_decoder.sv */
`timescale 1ns/1ns
`include "cmd_defs.svh"

module sc_param_decoder (
  input  logic               clk,
  input  logic               reset_n,
  input  cmd_pkg::cmd_beat_t beat,
  output cmd_pkg::sc_cfg_t   sc_cfg,
  output logic               param_load,
  output logic               counter_reset
);

  // n=1..64 selects channel n-1, anything else clears the mask
  // FF means every channel where allow_all is set
  function automatic logic [`CHN_NUM-1:0] onehot_mask(input logic [7:0] n,
                                                       input logic       allow_all);
    logic [`CHN_NUM-1:0] mask;
    mask = '0;
    if (n >= 8'd1 && n <= 8'(`CHN_NUM)) begin
      mask[6'(n - 8'd1)] = 1'b1;
    end else if (allow_all && n == 8'hFF) begin
      mask = '1;
    end
    return mask;
  endfunction

  logic hit_sel_sc;
  logic hit_sel_read;
  logic hit_asic_num;
  logic hit_ctest;
  logic hit_read_reg;
  logic hit_trig;
  logic hit_hold;
  logic hit_header;

  ////////////////////////////////////////////////////////////
  // Command match
  ////////////////////////////////////////////////////////////

  assign hit_sel_sc   = beat.valid && (beat.word == `SC_SEL_SC);
  assign hit_sel_read = beat.valid && (beat.word == `SC_SEL_READ);
  assign hit_asic_num = beat.valid && (beat.word[15:4] == `ASIC_NUM_PFX);
  assign hit_ctest    = beat.valid && (beat.word[15:8] == `CTEST_PFX);
  assign hit_read_reg = beat.valid && (beat.word[15:8] == `READ_REG_PFX);
  assign hit_trig     = beat.valid && (beat.word[15:4] == `TRIG_COINCID_PFX);
  assign hit_hold     = beat.valid && (beat.word[15:8] == `HOLD_DELAY_PFX);
  assign hit_header   = beat.valid && (beat.word[15:8] == `HEADER_PFX);

  ////////////////////////////////////////////////////////////
  // Held settings
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sc_cfg.sc_or_read   <= 1'b0;
      sc_cfg.asic_num     <= `ASIC_NUM_RST;
      sc_cfg.ctest_mask   <= '0;
      sc_cfg.read_mask    <= '0;
      sc_cfg.trig_coincid <= 2'b00;
      sc_cfg.hold_delay   <= 5'd0;
      sc_cfg.header       <= `HEADER_RST;
    end else begin
      // 0 selects slow control, 1 the read register
      if (hit_sel_sc) begin
        sc_cfg.sc_or_read <= 1'b0;
      end
      if (hit_sel_read) begin
        sc_cfg.sc_or_read <= 1'b1;
      end
      if (hit_asic_num) begin
        sc_cfg.asic_num <= beat.word[2:0];
      end
      if (hit_ctest) begin
        sc_cfg.ctest_mask <= onehot_mask(beat.word[7:0], 1'b1);
      end
      if (hit_read_reg) begin
        sc_cfg.read_mask <= onehot_mask(beat.word[7:0], 1'b0);
      end
      if (hit_trig) begin
        sc_cfg.trig_coincid <= beat.word[1:0];
      end
      if (hit_hold) begin
        sc_cfg.hold_delay <= beat.word[4:0];
      end
      // Header shifts out LSB first on the ASIC side
      if (hit_header) begin
        sc_cfg.header <= {<<{beat.word[7:0]}};
      end
    end
  end

  // One-cycle pulses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      param_load    <= 1'b0;
      counter_reset <= 1'b0;
    end else begin
      param_load    <= beat.valid && (beat.word == `PARAM_LOAD);
      counter_reset <= beat.valid && (beat.word == `CNT_RESET);
    end
  end

endmodule

/* source/cmd_queue.sv */
`timescale 1ns/1ns
`include "cmd_defs.svh"

module cmd_queue (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               in_valid,
  input  cmd_pkg::cmd_t      in_word,
  output logic               in_ready,
  output cmd_pkg::cmd_beat_t beat
);

  localparam logic [`QUEUE_AW:0] FULL_COUNT = `QUEUE_DEPTH;

  logic [`CMD_W-1:0]    mem [`QUEUE_DEPTH];
  logic [`QUEUE_AW-1:0] wr_ptr;
  logic [`QUEUE_AW-1:0] rd_ptr;
  logic [`QUEUE_AW:0]   count;
  logic                 push;
  logic                 pop;
  logic                 beat_valid;
  logic [`CMD_W-1:0]    beat_word;

  assign in_ready = (count != FULL_COUNT);
  assign push     = in_valid && in_ready;
  // Decoders never stall, so drain whenever anything is stored
  assign pop      = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

  // Pointers wrap naturally at QUEUE_DEPTH
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Registered output beat
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      beat_word <= mem[rd_ptr];
    end
  end

  assign beat = '{valid: beat_valid, word: beat_word};

endmodule

/* source/cmd_pkg.sv */
`include "cmd_defs.svh"

package cmd_pkg;

  // One host command word
  typedef logic [`CMD_W-1:0] cmd_t;

  // Queue output, valid for one cycle per word
  typedef struct packed {
    logic valid;
    cmd_t word;
  } cmd_beat_t;

  ////////////////////////////////////////////////////////////
  // Held configuration
  ////////////////////////////////////////////////////////////

  // ASIC slow-control settings
  typedef struct packed {
    logic                sc_or_read;
    logic [2:0]          asic_num;
    logic [`CHN_NUM-1:0] ctest_mask;
    logic [`CHN_NUM-1:0] read_mask;
    logic [1:0]          trig_coincid;
    logic [4:0]          hold_delay;
    logic [7:0]          header;
  } sc_cfg_t;

  // Thresholds are kept in ASIC bit order
  typedef struct packed {
    logic [`VTH_W-1:0]                  vth0;
    logic [`VTH_W-1:0]                  vth1;
    logic [`VTH_W-1:0]                  vth2;
    logic [`CHN_NUM-1:0][`TRIM_W-1:0]   trim;
  } dac_cfg_t;

  // Acquisition and S-curve test control
  typedef struct packed {
    logic                        acq_run;
    logic                        acq_mode;
    logic                        single_chn;
    logic                        ctest_input;
    logic [$clog2(`CHN_NUM)-1:0] test_chn;
    logic [15:0]                 cpt_max;
    logic                        sctest_run;
  } run_cfg_t;

endpackage

/* source/cmd_defs.svh */
`ifndef CMD_DEFS_SVH
`define CMD_DEFS_SVH

////////////////////////////////////////////////////////////
// Widths and sizes
////////////////////////////////////////////////////////////

`define CMD_W          16
`define QUEUE_DEPTH    16
`define QUEUE_AW       4
`define CHN_NUM        64
`define TRIM_W         4
`define VTH_W          10

////////////////////////////////////////////////////////////
// Command codes
////////////////////////////////////////////////////////////

// Run control, full word match
`define ACQ_START      16'hF0F0
`define ACQ_STOP       16'hF0F1
`define DATA_CLEAR     16'hF0FA

// Slow control, A class
`define SC_SEL_SC        16'hA0A0
`define SC_SEL_READ      16'hA0A1
`define ASIC_NUM_PFX     12'hA0B
`define CTEST_PFX        8'hA1
`define READ_REG_PFX     8'hA2
`define TRIG_COINCID_PFX 12'hA5A
`define HOLD_DELAY_PFX   8'hA6
`define CNT_RESET        16'hA7A1
`define HEADER_PFX       8'hAB
`define PARAM_LOAD       16'hD0A2

// Threshold DACs, top six bits of the word
`define VTH0_PFX       6'h30
`define VTH1_PFX       6'h31
`define VTH2_PFX       6'h32
`define TRIM_PFX       6'h33
// CC0x addresses channel 0
`define TRIM_CHN_BASE  8'd192

// S-curve test, E class
`define ACQ_MODE_SET   16'hE0A0
`define ACQ_MODE_CLR   16'hE0A1
`define SINGLE_SET     16'hE0B0
`define SINGLE_CLR     16'hE0B1
`define CTEST_IN_SET   16'hE0C0
`define CTEST_IN_CLR   16'hE0C1
`define SCTEST_START   16'hE0F0
`define SCTEST_STOP    16'hE0F1
`define TEST_CHN_PFX   8'hE1
`define CPT_MAX_PFX    8'hE2

// Reset values
`define ASIC_NUM_RST   3'd1
`define HEADER_RST     8'h55
`define VTH_RST        10'd1
`define CPT_MAX_RST    16'd10000

`endif
